/* logic/pci_defines.svh */
// Widths, IDs and BAR geometry of the PCI target model, pulled in with `include where needed
`ifndef PCI_DEFINES_SVH
`define PCI_DEFINES_SVH

// ************************************************
// Bus geometry
// ************************************************

// Multiplexed address and data path
`define PCI_AD_W 32

// ************************************************
// Local memory and BAR0
// ************************************************

// Sixteen words behind BAR0
`define PCI_MEM_WORDS 16
`define PCI_MEM_AW 4

// Low address bits ignored by BAR0 decode
`define PCI_BAR_MASK_BITS 6

// Device ID in the upper half, vendor ID in the lower half
`define PCI_DEVICE_ID 32'h5A17_0E3C

`endif

/* logic/pci_pkg.sv */
// Bus, request and state types of the PCI target subsystem, imported by every module
`include "pci_defines.svh"

package pci_pkg;

   // ************************************************
   // Encodings
   // ************************************************

   // Commands on cbe_n in the address phase, other codes are unsupported
   typedef enum logic [3:0] {
      cmd_mem_read  = 4'b0110,
      cmd_mem_write = 4'b0111,
      cmd_cfg_read  = 4'b1010,
      cmd_cfg_write = 4'b1011
   } pci_cmd_e;

   typedef enum logic [2:0] {
      st_idle,
      st_decode,
      st_local_wait,
      st_data,
      st_turnaround
   } tgt_state_e;

   // ************************************************
   // Bus and local side bundles
   // ************************************************

   // Lines driven by the bus master
   typedef struct packed {
      logic [`PCI_AD_W-1:0] ad;
      logic [3:0]           cbe_n;
      logic                 par;
      logic                 frame_n;
      logic                 irdy_n;
      logic                 idsel;
   } pci_mst_t;

   // Lines driven by the target, ad only valid with ad_oe
   typedef struct packed {
      logic [`PCI_AD_W-1:0] ad;
      logic                 ad_oe;
      logic                 par;
      logic                 devsel_n;
      logic                 trdy_n;
      logic                 perr_n;
   } pci_tgt_t;

   // Config access, byte enables active high
   typedef struct packed {
      logic                 strobe;
      logic                 write;
      logic [3:0]           index;
      logic [3:0]           be;
      logic [`PCI_AD_W-1:0] data;
   } cfg_req_t;

   typedef struct packed {
      logic                   strobe;
      logic                   write;
      logic [`PCI_MEM_AW-1:0] addr;
      logic [3:0]             be;
      logic [`PCI_AD_W-1:0]   data;
   } local_req_t;

endpackage

/* logic/pci_arbiter.sv */
// Round-robin arbiter for two bus masters, grant only moves while the bus is idle
module pci_arbiter
   import pci_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  pci_mst_t   bus,
   input  logic [1:0] req_n,
   output logic [1:0] gnt_n
);

   logic       bus_idle;
   // Index of the most recent grantee
   logic       last_q;
   logic       next_idx;
   // Active-high grant vector
   logic [1:0] gnt_q;

   // No address or data phase in progress
   assign bus_idle = bus.frame_n & bus.irdy_n;

   // Priority to the requester not served last time
   assign next_idx = ~last_q;

   // ************************************************
   // Grant update
   // ************************************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         gnt_q  <= 2'b00;
         last_q <= 1'b1;
      end else if (bus_idle) begin
         if (!req_n[next_idx]) begin
            // Waiting requester takes over
            gnt_q  <= 2'b01 << next_idx;
            last_q <= next_idx;
         end else if (!req_n[last_q]) begin
            // Sole requester keeps the bus
            gnt_q <= 2'b01 << last_q;
         end else begin
            // Nobody asking, no parking
            gnt_q <= 2'b00;
         end
      end
   end

   assign gnt_n = ~gnt_q;

endmodule

/* logic/pci_target.sv */
// PCI target bus interface, decodes each single-data-phase access and steers it to config or memory
`include "pci_defines.svh"

module pci_target
   import pci_pkg::*;
(
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  pci_mst_t                                 bus,
   output pci_tgt_t                                 tgt,
   output cfg_req_t                                 cfg,
   input  logic [`PCI_AD_W-1:0]                     cfg_rdata,
   input  logic                                     mem_enable,
   input  logic [`PCI_AD_W-`PCI_BAR_MASK_BITS-1:0] bar_base,
   output logic                                     parity_err,
   output local_req_t                               lreq,
   input  logic                                     lack,
   input  logic [`PCI_AD_W-1:0]                     lrdata
);

   tgt_state_e           state;
   pci_cmd_e             cmd_q;
   logic [`PCI_AD_W-1:0] addr_q;
   logic                 idsel_q;
   // Read data out or write data in
   logic [`PCI_AD_W-1:0] dat_q;
   logic [3:0]           be_q;

   logic devsel_n_q;
   logic trdy_n_q;
   logic ad_oe_q;
   logic par_q;
   logic lstb_q;
   logic cstb_q;
   logic chk_q;
   logic perr_pend_q;
   logic perr_n_q;
   logic parity_err_q;

   logic is_mem;
   logic is_cfg;
   logic is_write;
   logic mem_hit;
   logic cfg_hit;
   logic ready;

   assign is_mem   = (cmd_q == cmd_mem_read) || (cmd_q == cmd_mem_write);
   assign is_cfg   = (cmd_q == cmd_cfg_read) || (cmd_q == cmd_cfg_write);
   assign is_write = (cmd_q == cmd_mem_write) || (cmd_q == cmd_cfg_write);
   assign mem_hit  = is_mem && mem_enable &&
                     (addr_q[`PCI_AD_W-1:`PCI_BAR_MASK_BITS] == bar_base);
   assign cfg_hit  = is_cfg && idsel_q;
   // Memory reads hold off until the local ack
   assign ready    = (cmd_q == cmd_mem_read) ? lack : 1'b1;

   // ************************************************
   // Address, command and data capture
   // ************************************************

   always_ff @(posedge clk) begin
      if (state == st_idle && !bus.frame_n) begin
         addr_q  <= bus.ad;
         cmd_q   <= pci_cmd_e'(bus.cbe_n);
         idsel_q <= bus.idsel;
      end
      if (state == st_local_wait && ready && !is_write) begin
         dat_q <= (cmd_q == cmd_mem_read) ? lrdata : cfg_rdata;
      end
      if (state == st_data && !bus.irdy_n) begin
         be_q <= ~bus.cbe_n;
         if (is_write) begin
            dat_q <= bus.ad;
         end
      end
   end

   // ************************************************
   // Target FSM
   // ************************************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= st_idle;
         devsel_n_q <= 1'b1;
         trdy_n_q   <= 1'b1;
         ad_oe_q    <= 1'b0;
         lstb_q     <= 1'b0;
         cstb_q     <= 1'b0;
      end else begin
         // Strobes are single-cycle pulses
         lstb_q <= 1'b0;
         cstb_q <= 1'b0;
         case (state)
            st_idle: begin
               if (!bus.frame_n) begin
                  state <= st_decode;
               end
            end
            st_decode: begin
               // Medium decode
               if (mem_hit || cfg_hit) begin
                  devsel_n_q <= 1'b0;
                  state      <= st_local_wait;
                  // Reads are issued now
                  if (!is_write) begin
                     lstb_q <= mem_hit;
                     cstb_q <= cfg_hit;
                  end
               end else begin
                  state <= st_idle;
               end
            end
            st_local_wait: begin
               if (ready) begin
                  trdy_n_q <= 1'b0;
                  ad_oe_q  <= !is_write;
                  state    <= st_data;
               end
            end
            st_data: begin
               // Held here as long as irdy_n stays high
               if (!bus.irdy_n) begin
                  devsel_n_q <= 1'b1;
                  trdy_n_q   <= 1'b1;
                  ad_oe_q    <= 1'b0;
                  lstb_q     <= is_write && is_mem;
                  cstb_q     <= is_write && is_cfg;
                  state      <= st_turnaround;
               end
            end
            st_turnaround: begin
               state <= st_idle;
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // ************************************************
   // Parity
   // ************************************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         par_q        <= 1'b0;
         chk_q        <= 1'b0;
         perr_pend_q  <= 1'b0;
         perr_n_q     <= 1'b1;
         parity_err_q <= 1'b0;
      end else begin
         // par trails the driven ad by one clock
         par_q        <= ad_oe_q & (^{dat_q, bus.cbe_n});
         // Master par for write data shows up one clock after D
         chk_q        <= (state == st_data) && !bus.irdy_n && is_write && is_mem;
         perr_pend_q  <= chk_q && (bus.par != ^{dat_q, ~be_q});
         perr_n_q     <= ~perr_pend_q;
         parity_err_q <= perr_pend_q;
      end
   end

   always_comb begin
      tgt.ad       = dat_q;
      tgt.ad_oe    = ad_oe_q;
      tgt.par      = par_q;
      tgt.devsel_n = devsel_n_q;
      tgt.trdy_n   = trdy_n_q;
      tgt.perr_n   = perr_n_q;
   end

   always_comb begin
      cfg.strobe = cstb_q;
      cfg.write  = is_write;
      cfg.index  = addr_q[5:2];
      cfg.be     = be_q;
      cfg.data   = dat_q;
   end

   always_comb begin
      lreq.strobe = lstb_q;
      lreq.write  = is_write;
      lreq.addr   = addr_q[2 +: `PCI_MEM_AW];
      lreq.be     = be_q;
      lreq.data   = dat_q;
   end

   assign parity_err = parity_err_q;

endmodule

/* logic/pci_config.sv */
// PCI configuration space with ID, command and status, and BAR0, written and read by the target
`include "pci_defines.svh"

module pci_config
   import pci_pkg::*;
(
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  cfg_req_t                                 cfg,
   output logic [`PCI_AD_W-1:0]                     rdata,
   input  logic                                     parity_err,
   output logic                                     mem_enable,
   output logic [`PCI_AD_W-`PCI_BAR_MASK_BITS-1:0] bar_base
);

   localparam int unsigned bar_w = `PCI_AD_W - `PCI_BAR_MASK_BITS;

   logic                 mem_en_q;
   // Status bit 15, parity error detected
   logic                 perr_det_q;
   logic [bar_w-1:0]     bar_q;
   logic [`PCI_AD_W-1:0] bar_wr;
   logic                 wr_cmd;
   logic                 wr_bar;

   assign wr_cmd = cfg.strobe && cfg.write && (cfg.index == 4'd1);
   assign wr_bar = cfg.strobe && cfg.write && (cfg.index == 4'd4);

   // Byte-lane merge for BAR0
   always_comb begin
      bar_wr = {bar_q, {`PCI_BAR_MASK_BITS{1'b0}}};
      for (int i = 0; i < 4; i++) begin
         if (cfg.be[i]) begin
            bar_wr[8*i +: 8] = cfg.data[8*i +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_en_q   <= 1'b0;
         perr_det_q <= 1'b0;
         bar_q      <= '0;
      end else begin
         if (wr_cmd && cfg.be[0]) begin
            mem_en_q <= cfg.data[1];
         end
         // Status half of dword 1 is write-one-to-clear
         if (parity_err) begin
            perr_det_q <= 1'b1;
         end else if (wr_cmd && cfg.be[3] && cfg.data[31]) begin
            perr_det_q <= 1'b0;
         end
         if (wr_bar) begin
            bar_q <= bar_wr[`PCI_AD_W-1:`PCI_BAR_MASK_BITS];
         end
      end
   end

   // Read mux by dword index
   always_comb begin
      case (cfg.index)
         4'd0:    rdata = `PCI_DEVICE_ID;
         4'd1:    rdata = {perr_det_q, 29'd0, mem_en_q, 1'b0};
         4'd4:    rdata = {bar_q, {`PCI_BAR_MASK_BITS{1'b0}}};
         default: rdata = '0;
      endcase
   end

   assign mem_enable = mem_en_q;
   assign bar_base   = bar_q;

endmodule

/* logic/local_mem.sv */
// Local application memory behind BAR0, answering each request strobe one cycle later
`include "pci_defines.svh"

module local_mem
   import pci_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  local_req_t           req,
   output logic                 ack,
   output logic [`PCI_AD_W-1:0] rdata
);

   logic [`PCI_AD_W-1:0] mem [`PCI_MEM_WORDS];
   logic                 ack_q;

   // Storage and ack, cleared on reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
         for (int i = 0; i < `PCI_MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else begin
         ack_q <= req.strobe;
         if (req.strobe && req.write) begin
            for (int b = 0; b < 4; b++) begin
               if (req.be[b]) begin
                  mem[req.addr][8*b +: 8] <= req.data[8*b +: 8];
               end
            end
         end
      end
   end

   // Read data lines up with ack
   always_ff @(posedge clk) begin
      if (req.strobe && !req.write) begin
         rdata <= mem[req.addr];
      end
   end

   assign ack = ack_q;

endmodule

/* logic/pci_subsys.sv */
// Top level of the PCI target subsystem that ties arbiter, target, config space and memory together
`include "pci_defines.svh"

module pci_subsys
   import pci_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  pci_mst_t   bus,
   output pci_tgt_t   tgt,
   input  logic [1:0] req_n,
   output logic [1:0] gnt_n
);

   // Target to config space
   cfg_req_t                                 cfg;
   logic [`PCI_AD_W-1:0]                     cfg_rdata;
   logic                                     mem_enable;
   logic [`PCI_AD_W-`PCI_BAR_MASK_BITS-1:0] bar_base;
   logic                                     parity_err;

   // Target to local memory
   local_req_t                               lreq;
   logic                                     lack;
   logic [`PCI_AD_W-1:0]                     lrdata;

   pci_arbiter i_pci_arbiter (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (bus),
      .req_n (req_n),
      .gnt_n (gnt_n)
   );

   pci_target i_pci_target (
      .clk        (clk),
      .rst_n      (rst_n),
      .bus        (bus),
      .tgt        (tgt),
      .cfg        (cfg),
      .cfg_rdata  (cfg_rdata),
      .mem_enable (mem_enable),
      .bar_base   (bar_base),
      .parity_err (parity_err),
      .lreq       (lreq),
      .lack       (lack),
      .lrdata     (lrdata)
   );

   pci_config i_pci_config (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg        (cfg),
      .rdata      (cfg_rdata),
      .parity_err (parity_err),
      .mem_enable (mem_enable),
      .bar_base   (bar_base)
   );

   local_mem i_local_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (lreq),
      .ack   (lack),
      .rdata (lrdata)
   );

endmodule

/* verification/pci_tb.sv */
// Directed testbench for the PCI target subsystem that plays both bus masters and checks each access
`include "pci_defines.svh"

module pci_tb
   import pci_pkg::*;
();

   // About fifty accesses of 10 to 16 clocks each with a generous margin
   localparam int max_cycles = 3000;

   logic        clk;
   logic        rst_n;
   pci_mst_t    bus;
   pci_tgt_t    tgt;
   logic [1:0]  req_n;
   logic [1:0]  gnt_n;

   // Expected memory contents
   logic [31:0] ref_mem [`PCI_MEM_WORDS];
   logic [31:0] mem_base;
   logic [15:0] lfsr;
   int          cycles = 0;
   logic        master;
   logic        both_req;

   // Bus and grant seen at the previous falling edge
   logic        prev_frame_n = 1'b1;
   logic        prev_irdy_n = 1'b1;
   logic [1:0]  prev_gnt_n = 2'b11;

   pci_subsys i_pci_subsys (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (bus),
      .tgt   (tgt),
      .req_n (req_n),
      .gnt_n (gnt_n)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout: the tests did not finish within %0d clock cycles", max_cycles);
         $display("Errors found");
         $fatal(1);
      end
   end

   // ************************************************
   // Helpers
   // ************************************************

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
         $display("Errors found");
         $fatal(1);
      end
   endtask

   // Taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic logic [31:0] word_addr(input logic [3:0] w);
      return mem_base + {26'd0, w, 2'b00};
   endfunction

   // Grant must hold across any edge that saw frame_n or irdy_n low
   always @(negedge clk) begin
      if (rst_n && (!prev_frame_n || !prev_irdy_n)) begin
         check("arb_hold", {30'd0, prev_gnt_n}, {30'd0, gnt_n});
      end
      prev_frame_n = bus.frame_n;
      prev_irdy_n  = bus.irdy_n;
      prev_gnt_n   = gnt_n;
   end

   task automatic request_bus(input logic m);
      @(posedge clk);
      if (both_req) begin
         req_n <= 2'b00;
      end else if (!m) begin
         req_n <= 2'b10;
      end else begin
         req_n <= 2'b01;
      end
      do begin
         @(negedge clk);
      end while (gnt_n[m]);
   endtask

   // One address phase and one data phase with timing checks against edge A
   task automatic bus_cycle(input string name, input pci_cmd_e cmd, input logic [31:0] addr,
                            input logic sel, input logic [31:0] wdata, input logic [3:0] be_n,
                            input int waits, input logic bad_par, input logic exp_hit,
                            output logic [31:0] rdata);
      int          k;
      int          dev_edge;
      int          trdy_edge;
      logic        is_write;
      logic        done;
      logic [31:0] held;
      is_write  = (cmd == cmd_mem_write) || (cmd == cmd_cfg_write);
      k         = 0;
      dev_edge  = -1;
      trdy_edge = -1;
      done      = 1'b0;
      held      = '0;
      rdata     = '0;
      @(posedge clk);
      bus.frame_n <= 1'b0;
      bus.ad      <= addr;
      bus.cbe_n   <= cmd;
      bus.idsel   <= sel;
      // Edge A
      @(posedge clk);
      bus.frame_n <= 1'b1;
      bus.idsel   <= 1'b0;
      bus.cbe_n   <= be_n;
      bus.ad      <= is_write ? wdata : '0;
      bus.irdy_n  <= (waits > 0);
      while (!done) begin
         @(negedge clk);
         if (!tgt.devsel_n && dev_edge < 0) begin
            dev_edge = k;
         end
         if (!tgt.trdy_n) begin
            if (trdy_edge < 0) begin
               trdy_edge = k;
               held = tgt.ad;
               if (!is_write) begin
                  check({name, " ad_oe"}, 32'd1, {31'd0, tgt.ad_oe});
               end
            end else if (!is_write) begin
               check({name, " held data"}, held, tgt.ad);
            end
         end
         if (!tgt.trdy_n && !bus.irdy_n) begin
            done = 1'b1;
         end else if (dev_edge < 0 && k >= 5) begin
            // Master abort
            done = 1'b1;
         end
         @(posedge clk);
         k++;
         if (!done) begin
            bus.irdy_n <= (k < waits);
         end
      end
      // Edge D or the abort edge on a miss
      bus.irdy_n <= 1'b1;
      bus.ad     <= '0;
      bus.cbe_n  <= 4'hF;
      bus.par    <= is_write ? ((^{wdata, be_n}) ^ bad_par) : 1'b0;
      check({name, " claimed"}, {31'd0, exp_hit}, {31'd0, dev_edge >= 0});
      if (dev_edge >= 0) begin
         check({name, " devsel edge"}, 32'd1, dev_edge);
         check({name, " trdy edge"}, (cmd == cmd_mem_read) ? 32'd3 : 32'd2, trdy_edge);
         rdata = held;
         @(negedge clk);
         check({name, " devsel_n release"}, 32'd1, {31'd0, tgt.devsel_n});
         check({name, " trdy_n release"}, 32'd1, {31'd0, tgt.trdy_n});
         check({name, " ad_oe release"}, 32'd0, {31'd0, tgt.ad_oe});
         if (!is_write) begin
            check({name, " read par"}, {31'd0, ^{held, be_n}}, {31'd0, tgt.par});
         end
         @(posedge clk);
         bus.par <= 1'b0;
         // perr_n low only at D+2 after a bad write
         for (int n = 1; n <= 3; n++) begin
            @(negedge clk);
            check({name, " perr_n"}, {31'd0, !(bad_par && n == 2)}, {31'd0, tgt.perr_n});
         end
      end
   endtask

   // ************************************************
   // Master accesses
   // ************************************************

   task automatic cfg_write(input logic [3:0] index, input logic [31:0] data,
                            input logic [3:0] be_n);
      logic [31:0] rd_ignored;
      request_bus(master);
      bus_cycle("cfg_write", cmd_cfg_write, {26'd0, index, 2'b00}, 1'b1, data, be_n, 0,
                1'b0, 1'b1, rd_ignored);
   endtask

   task automatic cfg_read(input logic [3:0] index, output logic [31:0] data);
      request_bus(master);
      bus_cycle("cfg_read", cmd_cfg_read, {26'd0, index, 2'b00}, 1'b1, '0, 4'h0, 0,
                1'b0, 1'b1, data);
   endtask

   task automatic mem_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be_n, input logic bad_par);
      logic [31:0] rd_ignored;
      logic [31:0] mask;
      request_bus(master);
      bus_cycle("mem_write", cmd_mem_write, addr, 1'b0, data, be_n, 0, bad_par, 1'b1,
                rd_ignored);
      mask = {{8{~be_n[3]}}, {8{~be_n[2]}}, {8{~be_n[1]}}, {8{~be_n[0]}}};
      ref_mem[addr[5:2]] = (ref_mem[addr[5:2]] & ~mask) | (data & mask);
   endtask

   task automatic mem_read(input logic [31:0] addr, input int waits, input logic exp_hit,
                           output logic [31:0] data);
      request_bus(master);
      bus_cycle("mem_read", cmd_mem_read, addr, 1'b0, '0, 4'h0, waits, 1'b0, exp_hit, data);
   endtask

   // ************************************************
   // Directed tests
   // ************************************************

   task automatic reset_identity();
      logic [31:0] got;
      @(negedge clk);
      check("reset gnt_n", 32'd3, {30'd0, gnt_n});
      check("reset devsel_n", 32'd1, {31'd0, tgt.devsel_n});
      check("reset trdy_n", 32'd1, {31'd0, tgt.trdy_n});
      check("reset perr_n", 32'd1, {31'd0, tgt.perr_n});
      check("reset ad_oe", 32'd0, {31'd0, tgt.ad_oe});
      cfg_read(4'd0, got);
      check("device id", `PCI_DEVICE_ID, got);
      cfg_read(4'd1, got);
      check("command status reset", 32'd0, got);
      cfg_read(4'd4, got);
      check("bar0 reset", 32'd0, got);
   endtask

   task automatic decode_gating();
      logic [31:0] got;
      logic [31:0] bar_value;
      bar_value = 32'hC0DE_5A7F;
      // Memory space still disabled
      mem_read(32'h0000_0000, 0, 1'b0, got);
      cfg_write(4'd4, bar_value, 4'h0);
      cfg_write(4'd1, 32'h0000_0002, 4'h0);
      cfg_read(4'd4, got);
      mem_base = bar_value & ~((32'd1 << `PCI_BAR_MASK_BITS) - 32'd1);
      check("bar0 readback", mem_base, got);
      cfg_read(4'd1, got);
      check("memory enable", 32'h0000_0002, got);
      // First byte past the 64-byte window
      mem_read(mem_base + 32'd64, 0, 1'b0, got);
   endtask

   task automatic write_read_all();
      logic [31:0] data;
      logic [31:0] be;
      logic [31:0] waits;
      logic [31:0] got;
      for (int i = 0; i < `PCI_MEM_WORDS; i++) begin
         take_bits(32, data);
         take_bits(4, be);
         mem_write(word_addr(i[3:0]), data, be[3:0], 1'b0);
      end
      for (int i = 0; i < `PCI_MEM_WORDS; i++) begin
         take_bits(2, waits);
         mem_read(word_addr(i[3:0]), int'(waits), 1'b1, got);
         check("mem readback", ref_mem[i[3:0]], got);
      end
   endtask

   // Edge counts and read parity are checked inside bus_cycle
   task automatic bus_timing();
      logic [31:0] data;
      logic [31:0] got;
      take_bits(32, data);
      mem_write(word_addr(4'd2), data, 4'h0, 1'b0);
      mem_read(word_addr(4'd2), 0, 1'b1, got);
      check("timing read no wait", ref_mem[2], got);
      // irdy_n stays high for three clocks after trdy_n goes low
      mem_read(word_addr(4'd2), 6, 1'b1, got);
      check("timing read held by irdy", ref_mem[2], got);
      cfg_read(4'd4, got);
      check("timing cfg read", mem_base, got);
   endtask

   task automatic parity_error();
      logic [31:0] data;
      logic [31:0] got;
      take_bits(32, data);
      mem_write(word_addr(4'd5), data, 4'h0, 1'b1);
      cfg_read(4'd1, got);
      check("status parity set", 32'h8000_0002, got);
      // Write one to clear
      cfg_write(4'd1, 32'h8000_0002, 4'h0);
      cfg_read(4'd1, got);
      check("status parity cleared", 32'h0000_0002, got);
      mem_read(word_addr(4'd5), 0, 1'b1, got);
      check("word after bad parity", ref_mem[5], got);
   endtask

   task automatic arbitration();
      logic [1:0]  prev;
      logic [31:0] got;
      @(posedge clk);
      req_n    <= 2'b00;
      both_req = 1'b1;
      @(negedge clk);
      @(negedge clk);
      check("single grant", 32'd1, {31'd0, ^gnt_n});
      prev = gnt_n;
      repeat (6) begin
         @(negedge clk);
         check("grant alternates", {30'd0, prev[0], prev[1]}, {30'd0, gnt_n});
         prev = gnt_n;
      end
      // Grant hold during busy cycles is watched by the monitor
      master = 1'b1;
      cfg_read(4'd0, got);
      check("master 1 id", `PCI_DEVICE_ID, got);
      master = 1'b0;
      cfg_read(4'd0, got);
      check("master 0 id", `PCI_DEVICE_ID, got);
      both_req = 1'b0;
      @(posedge clk);
      req_n <= 2'b11;
   endtask

   initial begin
      rst_n    = 1'b0;
      req_n    = 2'b11;
      bus      = '{ad: '0, cbe_n: 4'hF, par: 1'b0, frame_n: 1'b1, irdy_n: 1'b1,
                   idsel: 1'b0};
      lfsr     = 16'd56;
      master   = 1'b0;
      both_req = 1'b0;
      mem_base = '0;
      for (int i = 0; i < `PCI_MEM_WORDS; i++) begin
         ref_mem[i[3:0]] = '0;
      end
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      reset_identity();
      decode_gating();
      write_read_all();
      bus_timing();
      parity_error();
      arbitration();
      $display("No errors");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+logic
logic/pci_pkg.sv
logic/pci_arbiter.sv
logic/pci_target.sv
logic/pci_config.sv
logic/local_mem.sv
logic/pci_subsys.sv
verification/pci_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module pci_tb -f vlog.f -o pci_tb_sim

./obj_dir/pci_tb_sim 2>&1 | tee sim.log

if grep -qx "No errors" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
